//--- rtl/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath and address width
`define CORE_DATA_W 32

`define CORE_REG_AW 5

// Data memory size in 32-bit words
`define CORE_DMEM_WORDS 64

`define CORE_RESET_PC 32'h0000_0000

`endif

//--- rtl/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    typedef enum logic [6:0]
    {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_src_e;

    typedef struct packed {
        alu_op_e                 alu_op;
        logic                    op_b_imm;   // Operand B from imm instead of rs2
        logic [`CORE_DATA_W-1:0] rs1_val;
        logic [`CORE_DATA_W-1:0] rs2_val;
        logic [`CORE_DATA_W-1:0] imm;
        logic [`CORE_REG_AW-1:0] rd;
        logic                    rd_we;
        logic                    mem_rd;
        logic                    mem_wr;
        wb_src_e                 wb_src;
        logic [`CORE_DATA_W-1:0] pc4;
    } id_ex_t;

    typedef struct packed {
        logic [`CORE_DATA_W-1:0] result;     // ALU result, also the memory address
        logic [`CORE_DATA_W-1:0] store_data;
        logic [`CORE_REG_AW-1:0] rd;
        logic                    rd_we;
        logic                    mem_rd;
        logic                    mem_wr;
        wb_src_e                 wb_src;
        logic [`CORE_DATA_W-1:0] pc4;
    } ex_mem_t;

    typedef struct packed {
        logic [`CORE_REG_AW-1:0] rd;
        logic                    rd_we;
        logic [`CORE_DATA_W-1:0] data;
    } wb_t;

endpackage

//--- rtl/if_stage.sv
`timescale 1ns/1ps

`include "core_cfg.svh"

module if_stage
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             imem_rdata_i,
    input  logic                    stall_i,
    input  logic                    brj_i,
    input  logic [`CORE_DATA_W-1:0] brj_pc_i,
    output logic [`CORE_DATA_W-1:0] imem_addr_o,
    output logic [31:0]             instr_o,
    output logic [`CORE_DATA_W-1:0] pc_o,
    output logic                    instr_vld_o
);

    logic [`CORE_DATA_W-1:0] pc;

    assign imem_addr_o = pc;    // Memory answers in the same cycle

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc          <= `CORE_RESET_PC;
            instr_o     <= '0;
            pc_o        <= '0;
            instr_vld_o <= 1'b0;
        end
        else if (brj_i)
        begin
            pc          <= brj_pc_i;
            instr_vld_o <= 1'b0;    // Drop the wrong-path fetch
        end
        else if (!stall_i)
        begin
            pc          <= pc + `CORE_DATA_W'(4);
            instr_o     <= imem_rdata_i;
            pc_o        <= pc;
            instr_vld_o <= 1'b1;
        end
    end

    // Decode must never redirect while it is holding for a load
    a_no_brj_in_stall : assert property (@(posedge clk) disable iff (!rst_n)
        !(brj_i && stall_i))
        else $error("redirect during load-use stall");

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

`include "core_cfg.svh"

module reg_file
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    we_i,
    input  logic [`CORE_REG_AW-1:0] waddr_i,
    input  logic [`CORE_DATA_W-1:0] wdata_i,
    input  logic [`CORE_REG_AW-1:0] raddr1_i,
    input  logic [`CORE_REG_AW-1:0] raddr2_i,
    output logic [`CORE_DATA_W-1:0] rdata1_o,
    output logic [`CORE_DATA_W-1:0] rdata2_o
);

    logic [`CORE_DATA_W-1:0] regs [2**`CORE_REG_AW];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 2**`CORE_REG_AW; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we_i && waddr_i != '0)
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];  // Old value on same-cycle write
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/1ps

`include "core_cfg.svh"

module id_stage import core_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             instr_i,
    input  logic [`CORE_DATA_W-1:0] pc_i,
    input  logic                    instr_vld_i,
    input  logic [`CORE_DATA_W-1:0] ex_alu_i,
    input  ex_mem_t                 ex_mem_i,
    input  wb_t                     wb_i,
    output id_ex_t                  id_ex_o,
    output logic                    stall_o,
    output logic                    brj_o,
    output logic [`CORE_DATA_W-1:0] brj_pc_o
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [`CORE_REG_AW-1:0] rs2;
    logic [`CORE_REG_AW-1:0] rd;
    alu_op_e                 alu_op;
    wb_src_e                 wb_src;
    logic                    op_b_imm;
    logic                    dec_we;
    logic                    mem_rd;
    logic                    mem_wr;
    logic                    use_rs1;
    logic                    use_rs2;
    logic                    is_br;
    logic                    br_ne;
    logic                    is_jal;
    logic [`CORE_DATA_W-1:0] imm;
    logic [`CORE_DATA_W-1:0] rf_rs1;
    logic [`CORE_DATA_W-1:0] rf_rs2;
    logic [`CORE_DATA_W-1:0] rs1_val;
    logic [`CORE_DATA_W-1:0] rs2_val;
    logic [`CORE_DATA_W-1:0] ex_val;
    logic [`CORE_DATA_W-1:0] mem_val;
    logic                    ex_load;
    logic                    mem_load;
    logic                    taken;
    id_ex_t                  id_ex_d;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign rd     = instr_i[11:7];

    always_comb
    begin
        alu_op   = ALU_ADD;
        wb_src   = WB_ALU;
        op_b_imm = 1'b0;
        imm      = '0;
        dec_we   = 1'b0;
        mem_rd   = 1'b0;
        mem_wr   = 1'b0;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        is_br    = 1'b0;
        br_ne    = 1'b0;
        is_jal   = 1'b0;
        if (instr_vld_i)
        begin
            case (opcode)
                OPC_OP:
                begin
                    if ((funct7 == 7'b0000000 && funct3 inside {3'b000, 3'b100, 3'b110, 3'b111})
                        || (funct7 == 7'b0100000 && funct3 == 3'b000))
                    begin
                        use_rs1 = 1'b1;
                        use_rs2 = 1'b1;
                        dec_we  = 1'b1;
                        case (funct3)
                            3'b100:  alu_op = ALU_XOR;
                            3'b110:  alu_op = ALU_OR;
                            3'b111:  alu_op = ALU_AND;
                            default: alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                        endcase
                    end
                end
                OPC_OP_IMM, OPC_LOAD:
                begin
                    if ((opcode == OPC_OP_IMM && funct3 == 3'b000)
                        || (opcode == OPC_LOAD && funct3 == 3'b010))
                    begin
                        use_rs1  = 1'b1;
                        dec_we   = 1'b1;
                        op_b_imm = 1'b1;
                        imm      = {{20{instr_i[31]}}, instr_i[31:20]};
                        mem_rd   = (opcode == OPC_LOAD);
                        wb_src   = (opcode == OPC_LOAD) ? WB_LOAD : WB_ALU;
                    end
                end
                OPC_STORE:
                begin
                    if (funct3 == 3'b010)
                    begin
                        use_rs1  = 1'b1;
                        use_rs2  = 1'b1;    // Store data
                        mem_wr   = 1'b1;
                        op_b_imm = 1'b1;
                        imm      = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                    end
                end
                OPC_BRANCH:
                begin
                    if (funct3[2:1] == 2'b00)
                    begin
                        use_rs1 = 1'b1;
                        use_rs2 = 1'b1;
                        is_br   = 1'b1;
                        br_ne   = funct3[0];
                        imm     = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                   instr_i[30:25], instr_i[11:8], 1'b0};
                    end
                end
                OPC_JAL:
                begin
                    is_jal = 1'b1;
                    dec_we = 1'b1;
                    wb_src = WB_PC4;
                    imm    = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                              instr_i[20], instr_i[30:21], 1'b0};
                end
                default:
                begin
                    dec_we = 1'b0;  // Unknown encodings act as no-ops
                end
            endcase
        end
    end

    reg_file u_reg_file
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .we_i     (wb_i.rd_we),
        .waddr_i  (wb_i.rd),
        .wdata_i  (wb_i.data),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .rdata1_o (rf_rs1),
        .rdata2_o (rf_rs2)
    );

    // JAL results are pc+4, not the ALU output
    assign ex_val  = (id_ex_o.wb_src == WB_PC4) ? id_ex_o.pc4 : ex_alu_i;
    assign mem_val = (ex_mem_i.wb_src == WB_PC4) ? ex_mem_i.pc4 : ex_mem_i.result;

    // Execute first, then memory, then writeback, then the register file
    function automatic logic [`CORE_DATA_W-1:0] fwd_sel(
        input logic [`CORE_REG_AW-1:0] rs,
        input logic [`CORE_DATA_W-1:0] rf_val
    );
        if (rs == '0)
            return rf_val;
        if (id_ex_o.rd_we && id_ex_o.rd == rs)
            return ex_val;
        if (ex_mem_i.rd_we && ex_mem_i.rd == rs)
            return mem_val;
        if (wb_i.rd_we && wb_i.rd == rs)
            return wb_i.data;
        return rf_val;
    endfunction

    always_comb
    begin
        rs1_val = fwd_sel(rs1, rf_rs1);
        rs2_val = fwd_sel(rs2, rf_rs2);
    end

    // Load result not ready yet: two cycles from execute, one from memory
    assign ex_load  = id_ex_o.mem_rd && id_ex_o.rd_we;
    assign mem_load = ex_mem_i.mem_rd && ex_mem_i.rd_we;
    assign stall_o  = (use_rs1 && ((ex_load && id_ex_o.rd == rs1)
                                   || (mem_load && ex_mem_i.rd == rs1)))
                   || (use_rs2 && ((ex_load && id_ex_o.rd == rs2)
                                   || (mem_load && ex_mem_i.rd == rs2)));

    assign taken    = is_jal || (is_br && ((rs1_val == rs2_val) != br_ne));
    assign brj_o    = taken && !stall_o;
    assign brj_pc_o = pc_i + imm;

    always_comb
    begin
        id_ex_d.alu_op   = alu_op;
        id_ex_d.op_b_imm = op_b_imm;
        id_ex_d.rs1_val  = rs1_val;
        id_ex_d.rs2_val  = rs2_val;
        id_ex_d.imm      = imm;
        id_ex_d.rd       = rd;
        id_ex_d.rd_we    = dec_we && (rd != '0) && !stall_o;  // Bubble while stalled
        id_ex_d.mem_rd   = mem_rd && !stall_o;
        id_ex_d.mem_wr   = mem_wr && !stall_o;
        id_ex_d.wb_src   = wb_src;
        id_ex_d.pc4      = pc_i + `CORE_DATA_W'(4);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            id_ex_o <= '0;
        end
        else
        begin
            id_ex_o <= id_ex_d;
        end
    end

    // Register file write port after the later stages
    a_no_x0_write : assert property (@(posedge clk) disable iff (!rst_n)
        wb_i.rd_we |-> wb_i.rd != '0)
        else $error("write enable set for x0");

endmodule

//--- rtl/ex_stage.sv
`timescale 1ns/1ps

`include "core_cfg.svh"

module ex_stage import core_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  id_ex_t                  id_ex_i,
    output logic [`CORE_DATA_W-1:0] alu_o,
    output ex_mem_t                 ex_mem_o
);

    logic [`CORE_DATA_W-1:0] op_b;

    assign op_b = id_ex_i.op_b_imm ? id_ex_i.imm : id_ex_i.rs2_val;

    // Also feeds decode forwarding
    always_comb
    begin
        case (id_ex_i.alu_op)
            ALU_SUB: alu_o = id_ex_i.rs1_val - op_b;
            ALU_AND: alu_o = id_ex_i.rs1_val & op_b;
            ALU_OR:  alu_o = id_ex_i.rs1_val | op_b;
            ALU_XOR: alu_o = id_ex_i.rs1_val ^ op_b;
            default: alu_o = id_ex_i.rs1_val + op_b;   // ADD, address calc
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ex_mem_o <= '0;
        end
        else
        begin
            ex_mem_o.result     <= alu_o;
            ex_mem_o.store_data <= id_ex_i.rs2_val;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.rd_we      <= id_ex_i.rd_we;
            ex_mem_o.mem_rd     <= id_ex_i.mem_rd;
            ex_mem_o.mem_wr     <= id_ex_i.mem_wr;
            ex_mem_o.wb_src     <= id_ex_i.wb_src;
            ex_mem_o.pc4        <= id_ex_i.pc4;
        end
    end

endmodule

//--- rtl/mem_stage.sv
`timescale 1ns/1ps

`include "core_cfg.svh"

module mem_stage import core_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem_i,
    output wb_t     wb_o,
    output logic    retire_vld_o
);

    localparam int IDX_W = $clog2(`CORE_DMEM_WORDS);

    logic [`CORE_DATA_W-1:0] dmem [`CORE_DMEM_WORDS];
    logic [IDX_W-1:0]        idx;
    logic [`CORE_DATA_W-1:0] wb_data;

    assign idx = ex_mem_i.result[IDX_W+1:2];    // Word address

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CORE_DMEM_WORDS; i++)
            begin
                dmem[i] <= '0;
            end
        end
        else if (ex_mem_i.mem_wr)
        begin
            dmem[idx] <= ex_mem_i.store_data;
        end
    end

    always_comb
    begin
        case (ex_mem_i.wb_src)
            WB_LOAD: wb_data = dmem[idx];    // Combinational read
            WB_PC4:  wb_data = ex_mem_i.pc4;
            default: wb_data = ex_mem_i.result;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_o         <= '0;
            retire_vld_o <= 1'b0;
        end
        else
        begin
            wb_o.rd      <= ex_mem_i.rd;
            wb_o.rd_we   <= ex_mem_i.rd_we;
            wb_o.data    <= wb_data;
            retire_vld_o <= ex_mem_i.rd_we && ex_mem_i.rd != '0;   // One strobe per write
        end
    end

    a_rd_wr_excl : assert property (@(posedge clk) disable iff (!rst_n)
        !(ex_mem_i.mem_rd && ex_mem_i.mem_wr))
        else $error("load and store in the same slot");

endmodule

//--- rtl/core_top.sv
`timescale 1ns/1ps

`include "core_cfg.svh"

module core_top import core_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [`CORE_DATA_W-1:0] imem_addr_o,
    input  logic [31:0]             imem_rdata_i,
    output wb_t                     retire_o,
    output logic                    retire_vld_o
);

    logic [31:0]             instr;
    logic [`CORE_DATA_W-1:0] pc;
    logic                    instr_vld;
    logic                    stall;
    logic                    brj;
    logic [`CORE_DATA_W-1:0] brj_pc;
    logic [`CORE_DATA_W-1:0] ex_alu;
    id_ex_t                  id_ex;
    ex_mem_t                 ex_mem;
    wb_t                     wb;

    assign retire_o = wb;   // Writeback doubles as the retire port

    if_stage u_if_stage
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_rdata_i (imem_rdata_i),
        .stall_i      (stall),
        .brj_i        (brj),
        .brj_pc_i     (brj_pc),
        .imem_addr_o  (imem_addr_o),
        .instr_o      (instr),
        .pc_o         (pc),
        .instr_vld_o  (instr_vld)
    );

    id_stage u_id_stage
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_i     (instr),
        .pc_i        (pc),
        .instr_vld_i (instr_vld),
        .ex_alu_i    (ex_alu),
        .ex_mem_i    (ex_mem),
        .wb_i        (wb),
        .id_ex_o     (id_ex),
        .stall_o     (stall),
        .brj_o       (brj),
        .brj_pc_o    (brj_pc)
    );

    ex_stage u_ex_stage
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex_i  (id_ex),
        .alu_o    (ex_alu),
        .ex_mem_o (ex_mem)
    );

    mem_stage u_mem_stage
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_mem_i     (ex_mem),
        .wb_o         (wb),
        .retire_vld_o (retire_vld_o)
    );

endmodule

//--- test/tb_core.sv
`timescale 1ns/1ps

`include "core_cfg.svh"

module tb_core import core_pkg::*;
();

    localparam int IMEM_WORDS = 512;
    localparam int N_TESTS    = 5;
    localparam int T_ALU      = 0;
    localparam int T_LDST     = 1;
    localparam int T_BRJ      = 2;
    localparam int T_RAND     = 3;
    localparam int T_X0       = 4;

    localparam logic [6:0] OPC_R   = 7'b0110011;
    localparam logic [6:0] OPC_I   = 7'b0010011;
    localparam logic [6:0] OPC_LD  = 7'b0000011;
    localparam logic [6:0] OPC_ST  = 7'b0100011;
    localparam logic [6:0] OPC_BR  = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [`CORE_DATA_W-1:0] imem_addr;
    logic [31:0]             imem_rdata;
    wb_t                     retire;
    logic                    retire_vld;

    logic [31:0] imem [IMEM_WORDS];
    int          prog_test [IMEM_WORDS];    // Test that owns each instruction
    int          prog_len;
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          exp_tst [$];
    int          ret_idx;
    int          test_err [N_TESTS];
    int          test_cnt [N_TESTS];
    int          extra_err;
    int          cycle_cnt;
    int          cycle_limit;
    string       test_name [N_TESTS] = '{"alu_fwd", "load_store", "branch_jal",
                                         "rand_prog", "x0_write"};

    core_top UUT
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .retire_o     (retire),
        .retire_vld_o (retire_vld)
    );

    always #20 clk = ~clk;

    assign imem_rdata = imem[imem_addr[10:2]];  // Same-cycle fetch answer

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] alu_rr(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_R};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_I};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OPC_LD};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_ST};
    endfunction

    function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BR};
    endfunction

    function automatic logic [31:0] jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic void push_instr(input logic [31:0] ins, input int tst);
        imem[prog_len]      = ins;
        prog_test[prog_len] = tst;
        prog_len++;
    endfunction

    function automatic void build_program();
        logic [31:0] rng;
        int          kind;
        int          rd;
        int          rs1;
        int          rs2;
        int          word;
        int          imm;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = 32'h0;                    // Opcode zero is a no-op
        prog_len = 0;
        // Dependent chain, hits every forwarding source
        push_instr(addi(1, 0, 5), T_ALU);
        push_instr(addi(2, 1, 7), T_ALU);
        push_instr(alu_rr(0, 0, 3, 1, 2), T_ALU);
        push_instr(alu_rr(32, 0, 4, 3, 1), T_ALU);
        push_instr(alu_rr(0, 4, 5, 4, 2), T_ALU);
        push_instr(alu_rr(0, 6, 6, 5, 3), T_ALU);
        push_instr(alu_rr(0, 7, 7, 6, 4), T_ALU);
        push_instr(addi(1, 1, -3), T_ALU);
        // Store/load pairs and load-use stalls
        push_instr(addi(8, 0, 40), T_LDST);
        push_instr(addi(9, 0, 291), T_LDST);
        push_instr(sw(9, 8, 0), T_LDST);
        push_instr(lw(10, 8, 0), T_LDST);
        push_instr(alu_rr(0, 0, 11, 10, 10), T_LDST);   // Load in execute
        push_instr(sw(11, 8, 4), T_LDST);
        push_instr(lw(12, 8, 4), T_LDST);
        push_instr(addi(13, 0, 1), T_LDST);
        push_instr(alu_rr(32, 0, 14, 12, 13), T_LDST);  // Load in memory
        push_instr(lw(15, 8, 0), T_LDST);
        push_instr(sw(15, 8, 8), T_LDST);
        push_instr(lw(16, 8, 8), T_LDST);
        // Branches both ways, then JAL
        push_instr(addi(17, 0, 3), T_BRJ);
        push_instr(addi(18, 0, 3), T_BRJ);
        push_instr(branch(0, 17, 18, 8), T_BRJ);
        push_instr(addi(19, 0, 99), T_BRJ);             // Skipped
        push_instr(branch(1, 17, 18, 8), T_BRJ);
        push_instr(addi(19, 0, 1), T_BRJ);
        push_instr(branch(0, 17, 19, 8), T_BRJ);
        push_instr(addi(20, 0, 2), T_BRJ);
        push_instr(branch(1, 17, 19, 8), T_BRJ);
        push_instr(addi(20, 0, 77), T_BRJ);             // Skipped
        push_instr(jal(21, 8), T_BRJ);
        push_instr(addi(22, 0, 55), T_BRJ);             // Skipped
        push_instr(addi(22, 21, 0), T_BRJ);
        push_instr(lw(23, 8, 0), T_BRJ);
        push_instr(branch(0, 23, 9, 8), T_BRJ);         // Branch waits on the load
        push_instr(addi(24, 0, 66), T_BRJ);
        push_instr(addi(24, 0, 4), T_BRJ);
        rng = 32'hcba3f9ad;
        for (int n = 0; n < 200; n++)
        begin
            rng  = lcg_next(rng);
            kind = int'(rng[31:29]);
            rd   = int'(rng[28:26]) % 7 + 1;
            rs1  = int'(rng[25:23]) % 7 + 1;
            rs2  = int'(rng[22:20]) % 7 + 1;
            word = int'(rng[19:14]);
            imm  = int'(rng[13:2]) - 2048;
            case (kind)
                0:       push_instr(alu_rr(0, 0, rd, rs1, rs2), T_RAND);
                1:       push_instr(alu_rr(32, 0, rd, rs1, rs2), T_RAND);
                2:       push_instr(alu_rr(0, 7, rd, rs1, rs2), T_RAND);
                3:       push_instr(alu_rr(0, 6, rd, rs1, rs2), T_RAND);
                4:       push_instr(alu_rr(0, 4, rd, rs1, rs2), T_RAND);
                5:       push_instr(addi(rd, rs1, imm), T_RAND);
                6:       push_instr(lw(rd, 0, word * 4), T_RAND);
                default: push_instr(sw(rs2, 0, word * 4), T_RAND);
            endcase
        end
        push_instr(addi(0, 0, 5), T_X0);
        push_instr(alu_rr(0, 0, 0, 1, 2), T_X0);
        push_instr(lw(0, 8, 0), T_X0);
        push_instr(alu_rr(0, 0, 25, 0, 0), T_X0);
        push_instr(addi(26, 0, 9), T_X0);
        push_instr(alu_rr(0, 6, 27, 0, 26), T_X0);
    endfunction

    // Architectural model, one instruction per step in program order
    function automatic void ref_run();
        logic [31:0] regs [32];
        logic [31:0] dmem [64];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] val;
        logic [31:0] npc;
        logic        wr;
        int          steps;
        for (int i = 0; i < 32; i++)
            regs[i] = 32'h0;
        for (int i = 0; i < 64; i++)
            dmem[i] = 32'h0;
        pc    = 32'h0;
        steps = 0;
        while (pc < 32'(4 * prog_len) && steps < 4 * prog_len)
        begin
            ins = imem[pc[10:2]];
            a   = regs[ins[19:15]];
            b   = regs[ins[24:20]];
            wr  = 1'b0;
            val = 32'h0;
            npc = pc + 32'd4;
            case (ins[6:0])
                OPC_R:
                begin
                    wr = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        {7'h00, 3'h0}: val = a + b;
                        {7'h20, 3'h0}: val = a - b;
                        {7'h00, 3'h4}: val = a ^ b;
                        {7'h00, 3'h6}: val = a | b;
                        {7'h00, 3'h7}: val = a & b;
                        default:       wr = 1'b0;
                    endcase
                end
                OPC_I:
                begin
                    wr  = (ins[14:12] == 3'h0);
                    val = a + {{20{ins[31]}}, ins[31:20]};
                end
                OPC_LD:
                begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    wr   = (ins[14:12] == 3'h2);
                    val  = dmem[addr[7:2]];
                end
                OPC_ST:
                begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    if (ins[14:12] == 3'h2)
                        dmem[addr[7:2]] = b;
                end
                OPC_BR:
                begin
                    if ((ins[14:12] == 3'h0 && a == b) || (ins[14:12] == 3'h1 && a != b))
                        npc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                OPC_JAL:
                begin
                    wr  = 1'b1;
                    val = pc + 32'd4;
                    npc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default:
                begin
                    wr = 1'b0;
                end
            endcase
            if (wr && ins[11:7] != 5'd0)
            begin
                regs[ins[11:7]] = val;
                exp_rd.push_back(ins[11:7]);
                exp_data.push_back(val);
                exp_tst.push_back(prog_test[pc[10:2]]);
            end
            pc = npc;
            steps++;
        end
    endfunction

    // Retire comparator
    always @(negedge clk)
    begin : compare_retire
        int t;
        if (rst_n && retire_vld)
        begin
            if (ret_idx >= exp_rd.size())
            begin
                $display("extra retire of x%0d = %08h after the last expected write",
                         retire.rd, retire.data);
                extra_err++;
            end
            else
            begin
                t = exp_tst[ret_idx];
                if (retire.rd_we !== 1'b1)
                begin
                    $display("%s: retire strobe for x%0d came without its write enable",
                             test_name[t], retire.rd);
                    test_err[t]++;
                end
                if (retire.rd !== exp_rd[ret_idx] || retire.data !== exp_data[ret_idx])
                begin
                    $display("ERR %s: expected x%0d = %08h, actual x%0d = %08h", test_name[t],
                             exp_rd[ret_idx], exp_data[ret_idx], retire.rd, retire.data);
                    test_err[t]++;
                end
                test_cnt[t]++;
                ret_idx++;
                if (ret_idx == exp_rd.size() || exp_tst[ret_idx] != t)
                    $display("test %s finished: %0d retires checked, %0d errors",
                             test_name[t], test_cnt[t], test_err[t]);
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
        begin
            $display("timeout after %0d cycles: %0d of %0d expected retires seen",
                     cycle_cnt, ret_idx, exp_rd.size());
            $display("TB FAILED");
            $finish;
        end
    end

    initial
    begin
        int n_pass;
        int n_fail;
        rst_n       = 1'b0;
        ret_idx     = 0;
        extra_err   = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        n_pass      = 0;
        n_fail      = 0;
        for (int i = 0; i < N_TESTS; i++)
        begin
            test_err[i] = 0;
            test_cnt[i] = 0;
        end
        build_program();
        ref_run();
        cycle_limit = 4 * prog_len + 50;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        while (ret_idx < exp_rd.size())
            @(posedge clk);
        repeat (8) @(posedge clk);              // Window for stray retires
        for (int i = 0; i < N_TESTS; i++)
        begin
            if (test_err[i] == 0)
                n_pass++;
            else
                n_fail++;
        end
        $display("summary: %0d tests passed, %0d tests failed, %0d extra retires",
                 n_pass, n_fail, extra_err);
        if (n_fail == 0 && extra_err == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/core_pkg.sv
rtl/if_stage.sv
rtl/reg_file.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/mem_stage.sv
rtl/core_top.sv
test/tb_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_core -f sim.f
status=0
./obj_dir/Vtb_core > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "TB FAILED" sim.log; then
    exit 1
fi
